// File: run.sh
#!/usr/bin/env bash
# Build the SD host testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f sdHost.f \
    --top-module sdHostTb \
    -o simSdHost

# The log decides the verdict, so a non-zero simulator exit is tolerated here
./obj_dir/simSdHost > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi

// File: sdHost.f
+incdir+verilog
verilog/sdPkg.sv
verilog/sdClockGen.sv
verilog/sdCmdTx.sv
verilog/sdRspRx.sv
verilog/sdHostCtrl.sv
verilog/sdHostTop.sv
verif/sdCardModel.sv
verif/sdHostTb.sv

// File: verif/sdCardModel.sv
module sdCardModel (
    input  logic sdClk,
    input  logic sdCmdOut,
    input  logic sdCmdOe,
    input  logic [47:0] replyFrame,
    input  logic replySilent,
    output logic sdCmdIn,
    output logic [47:0] lastFrame,
    output int frameCount
);

    logic [47:0] shiftIn;
    logic [47:0] answer;
    logic silent;
    int bitPos;

    // CMD idles high through the pull-up
    initial begin
        sdCmdIn = 1'b1;
        lastFrame = '0;
        frameCount = 0;
    end

    // ==============================
    // Frame capture and reply
    // ==============================

    always begin
        @(posedge sdClk);
        if (sdCmdOe && !sdCmdOut) begin
            // Start bit seen, collect the other 47 bits on rising edges
            shiftIn = '0;
            for (bitPos = 46; bitPos >= 0; bitPos--) begin
                @(posedge sdClk);
                shiftIn[bitPos] = sdCmdOut;
            end
            answer = replyFrame;
            silent = replySilent;
            lastFrame = shiftIn;
            frameCount = frameCount + 1;

            if (!silent) begin
                // Short gap, then the reply goes out on falling edges
                repeat (2) @(negedge sdClk);
                for (bitPos = 47; bitPos >= 0; bitPos--) begin
                    @(negedge sdClk);
                    sdCmdIn = answer[bitPos];
                end
                @(negedge sdClk);
                sdCmdIn = 1'b1;
            end
        end
    end

endmodule

// File: verif/sdHostTb.sv
`include "sdConsts.svh"

module sdHostTb;
    import sdPkg::*;

    localparam int MaxCmds = 16;
    localparam int ReadyTimeout = 4000;
    localparam int CreditTimeout = 20000;
    localparam int RspTimeout = 20000;

    logic clk;
    logic reset;
    logic cmdValid;
    sdCmdIndexT cmdIndex;
    sdArgT cmdArg;
    logic rspCreditReturn;
    logic sdCmdIn;
    logic dat2In;
    logic cmdCreditReturn;
    logic rspValid;
    sdCmdIndexT rspIndex;
    sdArgT rspArg;
    logic rspCrcOk;
    logic rspTimeout;
    logic sdPwrEn;
    logic sdClk;
    logic sdCmdOut;
    logic sdCmdOe;
    logic lvsSupported;
    sdHostStateT phase;

    // Stimulus table
    sdCmdIndexT stimIndex [MaxCmds];
    sdArgT stimArg [MaxCmds];
    int replyMode [MaxCmds];
    sdCmdIndexT replyIndex [MaxCmds];
    sdArgT replyArg [MaxCmds];
    logic [47:0] replyFrames [MaxCmds];
    logic replySilent [MaxCmds];
    int cmdTotal;
    logic dat2Level;

    logic [47:0] cardReply;
    logic cardSilent;
    logic [47:0] cardFrame;
    int cardCount;

    logic [31:0] lfsrState;
    int issuedCount;
    int returnCount;
    int preReadyPulses;
    logic rspCreditHeld;
    logic prevSdClk;
    logic prevOe;

    sdHostTop u_dut (
        .clk(clk),
        .reset(reset),
        .cmdValid(cmdValid),
        .cmdIndex(cmdIndex),
        .cmdArg(cmdArg),
        .rspCreditReturn(rspCreditReturn),
        .sdCmdIn(sdCmdIn),
        .dat2In(dat2In),
        .cmdCreditReturn(cmdCreditReturn),
        .rspValid(rspValid),
        .rspIndex(rspIndex),
        .rspArg(rspArg),
        .rspCrcOk(rspCrcOk),
        .rspTimeout(rspTimeout),
        .sdPwrEn(sdPwrEn),
        .sdClk(sdClk),
        .sdCmdOut(sdCmdOut),
        .sdCmdOe(sdCmdOe),
        .lvsSupported(lvsSupported),
        .phase(phase)
    );

    assign cardReply = (cardCount < MaxCmds) ? replyFrames[cardCount] : '1;
    assign cardSilent = (cardCount < MaxCmds) ? replySilent[cardCount] : 1'b1;

    sdCardModel u_card (
        .sdClk(sdClk),
        .sdCmdOut(sdCmdOut),
        .sdCmdOe(sdCmdOe),
        .replyFrame(cardReply),
        .replySilent(cardSilent),
        .sdCmdIn(sdCmdIn),
        .lastFrame(cardFrame),
        .frameCount(cardCount)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==============================
    // Reporting and reference models
    // ==============================

    task automatic reportError(input string msg);
        $display("ERR %0t %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic abortRun(input string msg);
        $display("%s at time %0t", msg, $time);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // CRC7 x^7 + x^3 + 1 over 40 bits, MSB first
    function automatic sdCrc7T crc7Of(input logic [39:0] bits);
        sdCrc7T crc;
        logic feedback;
        int i;
        crc = '0;
        for (i = 39; i >= 0; i--) begin
            feedback = crc[6] ^ bits[i];
            crc = {crc[5:0], 1'b0};
            if (feedback) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic int takeBits(input int count);
        int value;
        int i;
        logic feedback;
        value = 0;
        for (i = 0; i < count; i++) begin
            feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value = (value << 1) | int'(feedback);
        end
        return value;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================

    task automatic checkFrame(input sdCmdIndexT expIndex, input sdArgT expArg);
        logic [39:0] body;
        logic [47:0] expected;
        body = {2'b01, expIndex, expArg};
        expected = {body, crc7Of(body), 1'b1};
        if (cardFrame !== expected) begin
            reportError($sformatf("frame %h, expected %h", cardFrame, expected));
        end
    endtask

    task automatic checkResponse(input sdCmdIndexT expIndex, input sdArgT expArg,
                                 input logic expCrcOk, input logic expTimeout);
        if (rspCrcOk !== expCrcOk || rspTimeout !== expTimeout) begin
            reportError($sformatf("crcOk %b timeout %b, expected %b %b",
                                  rspCrcOk, rspTimeout, expCrcOk, expTimeout));
        end
        // Fields carry nothing after a timeout
        if (!expTimeout && (rspIndex !== expIndex || rspArg !== expArg)) begin
            reportError($sformatf("response %h %h, expected %h %h",
                                  rspIndex, rspArg, expIndex, expArg));
        end
    endtask

    task automatic checkPhase(input sdHostStateT expPhase);
        if (phase !== expPhase) begin
            reportError($sformatf("phase %0d, expected %0d", phase, expPhase));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            reportError($sformatf("%s is %b, expected %b", name, got, expected));
        end
    endtask

    // ==============================
    // Stimulus file
    // ==============================

    task automatic readStimulus();
        int fd;
        int code;
        int mode;
        logic haveDat2;
        string line;
        sdCmdIndexT idx;
        sdArgT arg;
        sdCmdIndexT rIdx;
        sdArgT rArg;
        logic [39:0] body;
        fd = $fopen("verif/sdStim.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open verif/sdStim.txt");
        end
        cmdTotal = 0;
        haveDat2 = 1'b0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            if (!haveDat2) begin
                code = $sscanf(line, "%d", mode);
                dat2Level = mode[0];
                haveDat2 = 1'b1;
            end else if (cmdTotal < MaxCmds) begin
                code = $sscanf(line, "%h %h %d %h %h", idx, arg, mode, rIdx, rArg);
                if (code != 5) begin
                    abortRun("malformed stimulus line");
                end
                stimIndex[cmdTotal] = idx;
                stimArg[cmdTotal] = arg;
                replyMode[cmdTotal] = mode;
                replyIndex[cmdTotal] = rIdx;
                replyArg[cmdTotal] = rArg;
                body = {2'b00, rIdx, rArg};
                replyFrames[cmdTotal] = {body, crc7Of(body) ^ ((mode == 1) ? 7'h01 : 7'h00),
                                         1'b1};
                replySilent[cmdTotal] = (mode == 2);
                cmdTotal++;
            end
        end
        $fclose(fd);
    endtask

    // ==============================
    // Host side processes
    // ==============================

    task automatic driveCommands();
        int k;
        int waitCycles;
        for (k = 0; k < cmdTotal; k++) begin
            repeat (takeBits(3)) @(posedge clk);
            waitCycles = 0;
            while (issuedCount - returnCount >= `SD_CMD_CREDITS) begin
                @(posedge clk);
                #1;
                waitCycles++;
                if (waitCycles > CreditTimeout) begin
                    abortRun("no command credit came back");
                end
            end
            @(posedge clk);
            #2;
            cmdValid = 1'b1;
            cmdIndex = stimIndex[k];
            cmdArg = stimArg[k];
            issuedCount++;
            @(posedge clk);
            #2;
            cmdValid = 1'b0;
        end
    endtask

    task automatic collectResponses();
        int k;
        int waitCycles;
        for (k = 0; k < cmdTotal; k++) begin
            waitCycles = 0;
            do begin
                @(posedge clk);
                waitCycles++;
                if (waitCycles > RspTimeout) begin
                    abortRun("no response arrived");
                end
            end while (!rspValid);
            if (cardCount != k + 1) begin
                abortRun("card frame count out of step with responses");
            end
            checkFrame(stimIndex[k], stimArg[k]);
            checkResponse(replyIndex[k], replyArg[k], replyMode[k] == 0, replyMode[k] == 2);
            // Hold the credit back, often longer than a whole command round trip
            repeat (takeBits(11)) @(posedge clk);
            @(posedge clk);
            #2;
            rspCreditReturn = 1'b1;
            rspCreditHeld = 1'b1;
            @(posedge clk);
            #2;
            rspCreditReturn = 1'b0;
        end
    endtask

    task automatic watchBringUp();
        int waitCycles;
        waitCycles = 0;
        while (phase != ready) begin
            @(posedge clk);
            waitCycles++;
            if (waitCycles > ReadyTimeout) begin
                abortRun("controller never reached ready");
            end
        end
        if (preReadyPulses != 1) begin
            abortRun("expected exactly one sdClk pulse before ready");
        end
        checkFlag("lvsSupported", lvsSupported, dat2Level);
    endtask

    // Edge and credit watcher
    always @(posedge clk) begin
        if (!reset) begin
            if (sdClk && !prevSdClk) begin
                if (!sdPwrEn) begin
                    abortRun("sdClk toggled with power off");
                end
                if (phase != ready) begin
                    preReadyPulses++;
                end
            end
            if (sdCmdOe && !prevOe && phase != ready) begin
                abortRun("CMD frame started before ready");
            end
            if (cmdCreditReturn) begin
                returnCount++;
                if (returnCount > issuedCount) begin
                    abortRun("more command credits returned than issued");
                end
            end
            if (rspValid) begin
                if (!rspCreditHeld) begin
                    abortRun("rspValid without a response credit");
                end
                rspCreditHeld = 1'b0;
            end
        end
        prevSdClk = sdClk;
        prevOe = sdCmdOe;
    end

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        reset = 1'b1;
        cmdValid = 1'b0;
        cmdIndex = '0;
        cmdArg = '0;
        rspCreditReturn = 1'b0;
        dat2In = 1'b0;
        dat2Level = 1'b0;
        lfsrState = 32'h0ac91142;
        issuedCount = 0;
        returnCount = 0;
        preReadyPulses = 0;
        rspCreditHeld = 1'b1;
        prevSdClk = 1'b0;
        prevOe = 1'b0;

        readStimulus();
        dat2In = dat2Level;

        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        checkPhase(off);
        checkFlag("sdPwrEn", sdPwrEn, 1'b0);
        checkFlag("sdCmdOe", sdCmdOe, 1'b0);
        checkFlag("sdClk", sdClk, 1'b0);
        checkFlag("rspValid", rspValid, 1'b0);
        checkFlag("cmdCreditReturn", cmdCreditReturn, 1'b0);

        fork
            watchBringUp();
            driveCommands();
            collectResponses();
        join

        repeat (4) @(posedge clk);
        if (issuedCount != cmdTotal || returnCount != cmdTotal || cardCount != cmdTotal) begin
            abortRun("command, credit and frame counts disagree");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: verif/sdStim.txt
# First data line: DAT2 level sampled during identification
# Then: index(hex) arg(hex) mode(0 good, 1 badCrc, 2 silent) replyIndex(hex) replyArg(hex)
1
00 00000000 0 00 00000000
08 000001aa 0 08 000001aa
37 00000000 0 37 00000120
29 40ff8000 1 29 00ff8000
29 40ff8000 2 00 00000000
02 00000000 0 3f 12345678
03 00000000 0 03 aaaa0000
07 aaaa0000 0 07 00000700

// File: verilog/sdClockGen.sv
`include "sdConsts.svh"

module sdClockGen (
    input  logic clk,
    input  logic reset,
    input  logic clkEnable,
    output logic sdRise,
    output logic sdFall,
    output logic sdClk
);

    localparam int DivBits = $clog2(`SD_CLK_DIV + 1);

    logic [DivBits-1:0] divCount;
    logic phaseHigh;
    logic lastCount;

    // Strobe the edge the free divider is about to make
    assign lastCount = (divCount == DivBits'(`SD_CLK_DIV - 1));
    assign sdRise = lastCount && !phaseHigh;
    assign sdFall = lastCount && phaseHigh;

    always_ff @(posedge clk) begin
        if (reset) begin
            divCount <= '0;
            phaseHigh <= 1'b0;
            sdClk <= 1'b0;
        end else begin
            if (lastCount) begin
                divCount <= '0;
                phaseHigh <= !phaseHigh;
            end else begin
                divCount <= divCount + 1'b1;
            end

            // Pin only moves on an enabled edge, otherwise it keeps its level
            // so the controller can stretch a single high pulse
            if (clkEnable && sdRise) begin
                sdClk <= 1'b1;
            end else if (clkEnable && sdFall) begin
                sdClk <= 1'b0;
            end
        end
    end

    // Each fall strobe comes one half period after a rise strobe
    assert property (@(posedge clk) disable iff (reset) sdFall |-> $past(sdRise, `SD_CLK_DIV));

endmodule

// File: verilog/sdCmdTx.sv
`include "sdConsts.svh"

module sdCmdTx (
    input  logic clk,
    input  logic reset,
    input  logic sdFall,
    input  logic txStart,
    input  sdPkg::sdCmdIndexT txIndex,
    input  sdPkg::sdArgT txArg,
    output logic txDone,
    output logic sdCmdOut,
    output logic sdCmdOe
);
    import sdPkg::*;

    // Start, transmission, index and argument; CRC and end bit follow
    localparam int BodyBits = `SD_FRAME_BITS - 8;
    localparam int CountBits = $clog2(`SD_FRAME_BITS + 1);

    logic [BodyBits-1:0] bodyShift;
    logic [CountBits-1:0] bitCount;
    sdCrc7T crc;
    logic busy;
    logic inBody;
    logic nextBit;

    assign inBody = (bitCount < CountBits'(BodyBits));

    // After the body the CRC register itself shifts out, filling with ones
    // so that its last bit out is the end bit
    assign nextBit = inBody ? bodyShift[BodyBits-1] : crc[6];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            bitCount <= '0;
            crc <= '0;
            txDone <= 1'b0;
            sdCmdOut <= 1'b0;
            sdCmdOe <= 1'b0;
        end else begin
            txDone <= 1'b0;
            if (txStart) begin
                busy <= 1'b1;
                bitCount <= '0;
                crc <= '0;
            end else if (busy && sdFall) begin
                if (bitCount == CountBits'(`SD_FRAME_BITS)) begin
                    // End bit has had its full period, release CMD
                    busy <= 1'b0;
                    sdCmdOe <= 1'b0;
                    sdCmdOut <= 1'b0;
                    txDone <= 1'b1;
                end else begin
                    sdCmdOut <= nextBit;
                    sdCmdOe <= 1'b1;
                    bitCount <= bitCount + 1'b1;
                    if (inBody) begin
                        crc <= sdCrc7Step(crc, nextBit);
                    end else begin
                        crc <= {crc[5:0], 1'b1};
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (txStart) begin
            bodyShift <= {2'b01, txIndex, txArg};
        end else if (busy && sdFall && inBody) begin
            bodyShift <= {bodyShift[BodyBits-2:0], 1'b0};
        end
    end

    // Controller waits for txDone before the next command
    assert property (@(posedge clk) disable iff (reset) txStart |-> !busy);

endmodule

// File: verilog/sdConsts.svh
`ifndef SD_CONSTS_SVH
`define SD_CONSTS_SVH

// ==============================
// SD clock
// ==============================

// clk cycles per half SD clock period
`define SD_CLK_DIV 4

// ==============================
// Bring-up delays, in SD periods
// ==============================

// Short values so simulation reaches ready quickly
`define SD_PWR_OFF_CYCLES 8
`define SD_PWR_ON_CYCLES 8
`define SD_LVS_PULSE_CYCLES 3

// ==============================
// Command channel
// ==============================

// Queue depth and the host's starting credit count
`define SD_CMD_CREDITS 2
// SD periods to wait for a response start bit
`define SD_RSP_TIMEOUT 64
`define SD_FRAME_BITS 48

`endif

// File: verilog/sdHostCtrl.sv
`include "sdConsts.svh"

module sdHostCtrl (
    input  logic clk,
    input  logic reset,
    input  logic sdRise,
    input  logic sdFall,
    input  logic dat2In,
    input  logic cmdValid,
    input  logic rspCreditReturn,
    input  logic txDone,
    input  logic rxDone,
    input  logic rxCrcOk,
    input  logic rxTimeout,
    input  sdPkg::sdCmdIndexT cmdIndex,
    input  sdPkg::sdCmdIndexT rxIndex,
    input  sdPkg::sdArgT cmdArg,
    input  sdPkg::sdArgT rxArg,
    output logic sdPwrEn,
    output logic clkEnable,
    output logic lvsSupported,
    output logic cmdCreditReturn,
    output logic txStart,
    output logic rxStart,
    output logic rspValid,
    output logic rspCrcOk,
    output logic rspTimeout,
    output sdPkg::sdCmdIndexT txIndex,
    output sdPkg::sdCmdIndexT rspIndex,
    output sdPkg::sdArgT txArg,
    output sdPkg::sdArgT rspArg,
    output sdPkg::sdHostStateT phase
);
    import sdPkg::*;

    localparam int QDepth = `SD_CMD_CREDITS;
    localparam int PtrBits = (QDepth > 1) ? $clog2(QDepth) : 1;
    localparam int DelayPwr = (`SD_PWR_OFF_CYCLES > `SD_PWR_ON_CYCLES) ?
                              `SD_PWR_OFF_CYCLES : `SD_PWR_ON_CYCLES;
    localparam int DelayMax = (DelayPwr > `SD_LVS_PULSE_CYCLES) ? DelayPwr : `SD_LVS_PULSE_CYCLES;
    localparam int DelayBits = $clog2(DelayMax + 1);

    typedef enum logic [1:0] {engIdle, engTx, engRx, engHold} engStateT;

    sdCmdIndexT qIndex [QDepth];
    sdArgT qArg [QDepth];
    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits-1:0] rdPtr;
    logic [PtrBits:0] qCount;
    logic [DelayBits-1:0] delay;
    engStateT engState;
    logic rspCredit;
    logic rspCreditSeen;
    logic startCmd;
    logic sendRsp;

    function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
        return (ptr == PtrBits'(QDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign txIndex = qIndex[rdPtr];
    assign txArg = qArg[rdPtr];
    assign startCmd = (phase == ready) && (engState == engIdle) && (qCount != '0);
    assign sendRsp = (engState == engHold) && rspCredit;

    // ==============================
    // Power and LVS sequencer
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= off;
            delay <= DelayBits'(`SD_PWR_OFF_CYCLES - 1);
            sdPwrEn <= 1'b0;
            clkEnable <= 1'b0;
            lvsSupported <= 1'b0;
        end else begin
            case (phase)
                off: if (sdRise) begin
                    if (delay == '0) begin
                        phase <= powerWait;
                        sdPwrEn <= 1'b1;
                        delay <= DelayBits'(`SD_PWR_ON_CYCLES - 1);
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                powerWait: if (sdRise) begin
                    if (delay == '0) begin
                        phase <= lvsPulse;
                        clkEnable <= 1'b1;
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                lvsPulse: if (sdRise) begin
                    // First enabled rise lifts sdClk, then it is held high
                    if (clkEnable) begin
                        clkEnable <= 1'b0;
                        delay <= DelayBits'(`SD_LVS_PULSE_CYCLES - 1);
                    end else if (delay == '0) begin
                        clkEnable <= 1'b1;
                        phase <= lvsSample;
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                lvsSample: begin
                    if (sdFall) begin
                        clkEnable <= 1'b0;
                    end
                    if (sdRise && !clkEnable) begin
                        lvsSupported <= dat2In;
                        phase <= ready;
                    end
                end
                ready: begin
                    // Clock runs only while a command is on the wire
                    if (startCmd) begin
                        clkEnable <= 1'b1;
                    end else if (sdFall && engState != engTx && engState != engRx) begin
                        clkEnable <= 1'b0;
                    end
                end
                default: phase <= off;
            endcase
        end
    end

    // ==============================
    // Command engine and credits
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            engState <= engIdle;
            txStart <= 1'b0;
            rxStart <= 1'b0;
            rspValid <= 1'b0;
            cmdCreditReturn <= 1'b0;
            rspCredit <= 1'b1;
            rspCreditSeen <= 1'b1;
            wrPtr <= '0;
            rdPtr <= '0;
            qCount <= '0;
        end else begin
            txStart <= startCmd;
            cmdCreditReturn <= txStart;
            rxStart <= 1'b0;
            rspValid <= sendRsp;
            rspCredit <= (rspCredit && !sendRsp) || rspCreditReturn;
            // Credit as seen from the result port pulses alone
            rspCreditSeen <= (rspCreditSeen && !rspValid) || rspCreditReturn;

            if (cmdValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (txStart) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({cmdValid, txStart})
                2'b10: qCount <= qCount + 1'b1;
                2'b01: qCount <= qCount - 1'b1;
                default: qCount <= qCount;
            endcase

            case (engState)
                engIdle: if (startCmd) engState <= engTx;
                engTx: if (txDone) begin
                    rxStart <= 1'b1;
                    engState <= engRx;
                end
                engRx: if (rxDone) engState <= engHold;
                engHold: if (sendRsp) engState <= engIdle;
                default: engState <= engIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmdValid) begin
            qIndex[wrPtr] <= cmdIndex;
            qArg[wrPtr] <= cmdArg;
        end
    end

    // Result waits here until a response credit is free
    always_ff @(posedge clk) begin
        if (rxDone && engState == engRx) begin
            rspIndex <= rxIndex;
            rspArg <= rxArg;
            rspCrcOk <= rxCrcOk;
            rspTimeout <= rxTimeout;
        end
    end

    assert property (@(posedge clk) disable iff (reset) cmdValid |-> qCount < QDepth);
    assert property (@(posedge clk) disable iff (reset) rspValid |-> rspCreditSeen);
    assert property (@(posedge clk) disable iff (reset) txStart |-> phase == ready);

endmodule

// File: verilog/sdHostTop.sv
module sdHostTop (
    input  logic clk,
    input  logic reset,
    input  logic cmdValid,
    input  sdPkg::sdCmdIndexT cmdIndex,
    input  sdPkg::sdArgT cmdArg,
    input  logic rspCreditReturn,
    input  logic sdCmdIn,
    input  logic dat2In,
    output logic cmdCreditReturn,
    output logic rspValid,
    output sdPkg::sdCmdIndexT rspIndex,
    output sdPkg::sdArgT rspArg,
    output logic rspCrcOk,
    output logic rspTimeout,
    output logic sdPwrEn,
    output logic sdClk,
    output logic sdCmdOut,
    output logic sdCmdOe,
    output logic lvsSupported,
    output sdPkg::sdHostStateT phase
);
    import sdPkg::*;

    logic sdRise;
    logic sdFall;
    logic clkEnable;
    logic txStart;
    logic txDone;
    logic rxStart;
    logic rxDone;
    logic rxCrcOk;
    logic rxTimeout;
    sdCmdIndexT txIndex;
    sdCmdIndexT rxIndex;
    sdArgT txArg;
    sdArgT rxArg;

    sdClockGen u_clockGen (
        .clk(clk),
        .reset(reset),
        .clkEnable(clkEnable),
        .sdRise(sdRise),
        .sdFall(sdFall),
        .sdClk(sdClk)
    );

    sdCmdTx u_cmdTx (
        .clk(clk),
        .reset(reset),
        .sdFall(sdFall),
        .txStart(txStart),
        .txIndex(txIndex),
        .txArg(txArg),
        .txDone(txDone),
        .sdCmdOut(sdCmdOut),
        .sdCmdOe(sdCmdOe)
    );

    sdRspRx u_rspRx (
        .clk(clk),
        .reset(reset),
        .sdRise(sdRise),
        .rxStart(rxStart),
        .sdCmdIn(sdCmdIn),
        .rxDone(rxDone),
        .rxCrcOk(rxCrcOk),
        .rxTimeout(rxTimeout),
        .rxIndex(rxIndex),
        .rxArg(rxArg)
    );

    sdHostCtrl u_ctrl (
        .clk(clk),
        .reset(reset),
        .sdRise(sdRise),
        .sdFall(sdFall),
        .dat2In(dat2In),
        .cmdValid(cmdValid),
        .rspCreditReturn(rspCreditReturn),
        .txDone(txDone),
        .rxDone(rxDone),
        .rxCrcOk(rxCrcOk),
        .rxTimeout(rxTimeout),
        .cmdIndex(cmdIndex),
        .rxIndex(rxIndex),
        .cmdArg(cmdArg),
        .rxArg(rxArg),
        .sdPwrEn(sdPwrEn),
        .clkEnable(clkEnable),
        .lvsSupported(lvsSupported),
        .cmdCreditReturn(cmdCreditReturn),
        .txStart(txStart),
        .rxStart(rxStart),
        .rspValid(rspValid),
        .rspCrcOk(rspCrcOk),
        .rspTimeout(rspTimeout),
        .txIndex(txIndex),
        .rspIndex(rspIndex),
        .txArg(txArg),
        .rspArg(rspArg),
        .phase(phase)
    );

endmodule

// File: verilog/sdPkg.sv
package sdPkg;

    // ==============================
    // Frame fields
    // ==============================

    typedef logic [5:0] sdCmdIndexT;
    typedef logic [31:0] sdArgT;

    // CRC7, generator x^7 + x^3 + 1, starts at zero
    typedef logic [6:0] sdCrc7T;

    // ==============================
    // Controller phases
    // ==============================

    typedef enum logic [2:0] {
        off,
        powerWait,
        lvsPulse,
        lvsSample,
        ready
    } sdHostStateT;

    // One serial CRC7 step, MSB first
    function automatic sdCrc7T sdCrc7Step(input sdCrc7T crc, input logic dataBit);
        logic feedback;
        feedback = crc[6] ^ dataBit;
        return {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
    endfunction

endpackage

// File: verilog/sdRspRx.sv
`include "sdConsts.svh"

module sdRspRx (
    input  logic clk,
    input  logic reset,
    input  logic sdRise,
    input  logic rxStart,
    input  logic sdCmdIn,
    output logic rxDone,
    output logic rxCrcOk,
    output logic rxTimeout,
    output sdPkg::sdCmdIndexT rxIndex,
    output sdPkg::sdArgT rxArg
);
    import sdPkg::*;

    localparam int CountBits = $clog2(`SD_FRAME_BITS + 1);
    localparam int WaitBits = $clog2(`SD_RSP_TIMEOUT + 1);
    // Last frame bit covered by the CRC
    localparam int CrcLastBit = `SD_FRAME_BITS - 9;

    logic hunting;
    logic receiving;
    logic [WaitBits-1:0] waitCount;
    logic [CountBits-1:0] bitCount;
    sdCrc7T crc;

    // Everything after the start bit; MSB is the transmission bit
    logic [`SD_FRAME_BITS-2:0] frame;

    // ==============================
    // Field extraction
    // ==============================

    assign rxIndex = frame[45:40];
    assign rxArg = frame[39:8];

    // ==============================
    // Start bit hunt and shift-in
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            hunting <= 1'b0;
            receiving <= 1'b0;
            waitCount <= '0;
            bitCount <= '0;
            crc <= '0;
            rxDone <= 1'b0;
            rxCrcOk <= 1'b0;
            rxTimeout <= 1'b0;
        end else begin
            rxDone <= 1'b0;
            if (rxStart) begin
                hunting <= 1'b1;
                receiving <= 1'b0;
                waitCount <= '0;
            end else if (sdRise && hunting) begin
                if (!sdCmdIn) begin
                    // A zero start bit leaves a zero CRC unchanged
                    hunting <= 1'b0;
                    receiving <= 1'b1;
                    bitCount <= CountBits'(1);
                    crc <= '0;
                end else if (waitCount == WaitBits'(`SD_RSP_TIMEOUT - 1)) begin
                    hunting <= 1'b0;
                    rxDone <= 1'b1;
                    rxTimeout <= 1'b1;
                    rxCrcOk <= 1'b0;
                end else begin
                    waitCount <= waitCount + 1'b1;
                end
            end else if (sdRise && receiving) begin
                bitCount <= bitCount + 1'b1;
                if (bitCount <= CountBits'(CrcLastBit)) begin
                    crc <= sdCrc7Step(crc, sdCmdIn);
                end
                if (bitCount == CountBits'(`SD_FRAME_BITS - 1)) begin
                    // Incoming bit is the end bit; CRC field sits in frame[6:0]
                    receiving <= 1'b0;
                    rxDone <= 1'b1;
                    rxTimeout <= 1'b0;
                    rxCrcOk <= (frame[6:0] == crc) && sdCmdIn;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sdRise && receiving) begin
            frame <= {frame[`SD_FRAME_BITS-3:0], sdCmdIn};
        end
    end

endmodule
